// ==== verilog/hyper_pkg.sv ====
/*
 * Shared types and constants for the HyperBus controller.
 * Memory space only, linear bursts of one 32-bit word.
 */
`default_nettype none

package hyper_pkg;

    // Encoded so the op maps straight onto the CA read bit
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } hyper_op_e;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_CA      = 3'd1,
        ST_LATENCY = 3'd2,
        ST_DATA    = 3'd3,
        ST_DONE    = 3'd4
    } hyper_state_e;

    // Command-address bit positions
    localparam int unsigned CaRwBit    = 47;
    localparam int unsigned CaSpaceBit = 46;
    localparam int unsigned CaBurstBit = 45;

    // Transaction geometry in bytes
    localparam int unsigned CaBytes   = 6;
    localparam int unsigned WordBytes = 4;

endpackage

`default_nettype wire

// ==== verilog/hyper_ca_builder.sv ====
/*
 * Command-address word for a memory-space linear access.
 * AddrWidth must stay below 32, the halfword address is 32 bits.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_ca_builder #(
    parameter int unsigned AddrWidth = 20
) (
    input  logic                  sys_clk,
    input  logic                  reset_i,
    input  logic                  load_i,
    input  logic                  shift_i,
    input  hyper_pkg::hyper_op_e  op_i,
    input  logic [AddrWidth-1:0]  addr_i,
    output logic [7:0]            ca_byte_o
);

    localparam int unsigned CaBits = hyper_pkg::CaBytes * 8;

    logic [31:0]       haddr;
    logic [CaBits-1:0] ca_word;
    logic [CaBits-1:0] ca_q;

    // Word address to halfword address
    assign haddr = 32'({addr_i, 1'b0});

    always_comb begin
        ca_word                        = '0;
        ca_word[hyper_pkg::CaRwBit]    = (op_i == hyper_pkg::OP_READ);
        ca_word[hyper_pkg::CaSpaceBit] = 1'b0;
        ca_word[hyper_pkg::CaBurstBit] = 1'b1;
        ca_word[44:16]                 = haddr[31:3];
        ca_word[2:0]                   = haddr[2:0];
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            ca_q <= '0;
        end else if (load_i) begin
            ca_q <= ca_word;
        end else if (shift_i) begin
            ca_q <= {ca_q[CaBits-9:0], 8'h00};
        end
    end

    assign ca_byte_o = ca_q[CaBits-1 -: 8];

endmodule

`default_nettype wire

// ==== verilog/hyper_data_path.sv ====
/*
 * Byte lanes for one word. Writes go out byte 0 first with RWDS high
 * for masked bytes. The read word is only complete in the cycle the
 * last byte sits on rd_byte_i, which is when the response is flagged.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_data_path (
    input  logic        sys_clk,
    input  logic        reset_i,
    input  logic        load_i,
    input  logic        shift_i,
    input  logic        capture_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  be_i,
    input  logic [7:0]  rd_byte_i,
    output logic [7:0]  wr_byte_o,
    output logic        wr_mask_o,
    output logic [31:0] rd_word_o
);

    localparam int unsigned WordBits = hyper_pkg::WordBytes * 8;
    localparam int unsigned HeldBits = WordBits - 8;

    logic [WordBits-1:0]             wdata_q;
    logic [hyper_pkg::WordBytes-1:0] mask_q;
    logic [HeldBits-1:0]             rd_q;

    // Write side
    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            wdata_q <= '0;
            mask_q  <= '1;
        end else if (load_i) begin
            wdata_q <= wdata_i;
            mask_q  <= ~be_i;
        end else if (shift_i) begin
            wdata_q <= {8'h00, wdata_q[WordBits-1:8]};
            mask_q  <= {1'b1, mask_q[hyper_pkg::WordBytes-1:1]};
        end
    end

    assign wr_byte_o = wdata_q[7:0];
    assign wr_mask_o = mask_q[0];

    // Read side, earlier bytes drift toward byte 0
    always_ff @(posedge sys_clk) begin
        if (capture_i) begin
            rd_q <= {rd_byte_i, rd_q[HeldBits-1:8]};
        end
    end

    assign rd_word_o = {rd_byte_i, rd_q};

endmodule

`default_nettype wire

// ==== verilog/hyper_io_pad.sv ====
/*
 * Pin registers. One byte per sys_clk, ck_o toggles once per byte.
 * Masked bytes still appear on DQ, RWDS tells the memory to drop them.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_io_pad (
    input  logic       sys_clk,
    input  logic       reset_i,
    input  logic       active_i,
    input  logic [1:0] byte_sel_i,
    input  logic [7:0] ca_byte_i,
    input  logic [7:0] wr_byte_i,
    input  logic       wr_mask_i,
    input  logic       dq_oe_i,
    input  logic       rwds_oe_i,
    output logic       cs_n_o,
    output logic       ck_o,
    output logic       reset_n_o,
    output logic [7:0] rd_byte_o,
    inout  wire  [7:0] dq_io,
    inout  wire        rwds_io
);

    logic [7:0] dq_q;
    logic       rwds_q;
    logic       dq_oe_q, rwds_oe_q;

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            cs_n_o    <= 1'b1;
            ck_o      <= 1'b0;
            dq_oe_q   <= 1'b0;
            rwds_oe_q <= 1'b0;
        end else begin
            cs_n_o    <= ~active_i;
            ck_o      <= active_i ? ~ck_o : 1'b0;
            dq_oe_q   <= dq_oe_i;
            rwds_oe_q <= rwds_oe_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        dq_q      <= byte_sel_i[0] ? ca_byte_i : (byte_sel_i[1] ? wr_byte_i : 8'h00);
        rwds_q    <= wr_mask_i;
        rd_byte_o <= dq_io;
    end

    assign dq_io     = dq_oe_q ? dq_q : 8'bz;
    assign rwds_io   = rwds_oe_q ? rwds_q : 1'bz;
    assign reset_n_o = ~reset_i;

endmodule

`default_nettype wire

// ==== verilog/hyper_ctrl_fsm.sv ====
/*
 * Command queue and transaction sequencer. The host must hold a credit
 * before raising cmd_valid_i, so the queue has no full check.
 * An empty queue is bypassed so a command starts the cycle it arrives.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_ctrl_fsm #(
    parameter int unsigned AddrWidth  = 20,
    parameter int unsigned Latency    = 6,
    parameter int unsigned CmdCredits = 2
) (
    input  logic                  sys_clk,
    input  logic                  reset_i,
    input  logic                  cmd_valid_i,
    input  hyper_pkg::hyper_op_e  cmd_op_i,
    input  logic [AddrWidth-1:0]  cmd_addr_i,
    input  logic [31:0]           cmd_wdata_i,
    input  logic [3:0]            cmd_be_i,
    output logic                  credit_o,
    output logic                  rsp_valid_o,
    output hyper_pkg::hyper_op_e  q_op_o,
    output logic [AddrWidth-1:0]  q_addr_o,
    output logic [31:0]           q_wdata_o,
    output logic [3:0]            q_be_o,
    output logic                  ca_load_o,
    output logic                  ca_shift_o,
    output logic                  dp_load_o,
    output logic                  dp_shift_o,
    output logic                  dp_capture_o,
    output logic [1:0]            byte_sel_o,
    output logic                  bus_active_o,
    output logic                  dq_oe_o,
    output logic                  rwds_oe_o
);

    localparam int unsigned PtrW = (CmdCredits > 1) ? $clog2(CmdCredits) : 1;
    localparam int unsigned CntW = $clog2(Latency + hyper_pkg::CaBytes + 1);
    // Pad output plus pad input register
    localparam int unsigned RdDelay = 2;

    hyper_pkg::hyper_op_e  op_mem    [CmdCredits];
    logic [AddrWidth-1:0]  addr_mem  [CmdCredits];
    logic [31:0]           wdata_mem [CmdCredits];
    logic [3:0]            be_mem    [CmdCredits];
    logic [PtrW-1:0]       wr_ptr_q, rd_ptr_q;
    logic [$clog2(CmdCredits+1)-1:0] count_q;

    hyper_pkg::hyper_state_e state_q;
    hyper_pkg::hyper_op_e    cur_op_q;
    logic [CntW-1:0]         cnt_q;
    logic                    bypass, start, is_write;

    assign bypass   = (count_q == '0);
    assign q_op_o    = bypass ? cmd_op_i    : op_mem[rd_ptr_q];
    assign q_addr_o  = bypass ? cmd_addr_i  : addr_mem[rd_ptr_q];
    assign q_wdata_o = bypass ? cmd_wdata_i : wdata_mem[rd_ptr_q];
    assign q_be_o    = bypass ? cmd_be_i    : be_mem[rd_ptr_q];

    // DONE doubles as the idle gap between back-to-back transactions
    assign start = (state_q == hyper_pkg::ST_IDLE || state_q == hyper_pkg::ST_DONE)
                   && (!bypass || cmd_valid_i);
    assign is_write = (cur_op_q == hyper_pkg::OP_WRITE);

    assign ca_load_o    = start;
    assign ca_shift_o   = (state_q == hyper_pkg::ST_CA) && (cnt_q != CntW'(hyper_pkg::CaBytes - 1));
    assign dp_load_o    = start && (q_op_o == hyper_pkg::OP_WRITE);
    assign dp_shift_o   = (state_q == hyper_pkg::ST_DATA) && is_write
                          && (cnt_q != CntW'(hyper_pkg::WordBytes - 1));
    assign dp_capture_o = !is_write && (((state_q == hyper_pkg::ST_DATA) && (cnt_q >= CntW'(RdDelay)))
                                        || (state_q == hyper_pkg::ST_DONE));

    // One-hot source, bit 0 CA and bit 1 write data
    assign byte_sel_o   = {(state_q == hyper_pkg::ST_DATA) && is_write, state_q == hyper_pkg::ST_CA};
    assign bus_active_o = (state_q == hyper_pkg::ST_CA) || (state_q == hyper_pkg::ST_LATENCY)
                          || (state_q == hyper_pkg::ST_DATA);
    assign dq_oe_o      = byte_sel_o[0] || byte_sel_o[1];
    assign rwds_oe_o    = byte_sel_o[1];

    always_ff @(posedge sys_clk) begin
        if (cmd_valid_i) begin
            op_mem[wr_ptr_q]    <= cmd_op_i;
            addr_mem[wr_ptr_q]  <= cmd_addr_i;
            wdata_mem[wr_ptr_q] <= cmd_wdata_i;
            be_mem[wr_ptr_q]    <= cmd_be_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            state_q     <= hyper_pkg::ST_IDLE;
            cur_op_q    <= hyper_pkg::OP_WRITE;
            cnt_q       <= '0;
            credit_o    <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            if (cmd_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(CmdCredits - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (start) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(CmdCredits - 1)) ? '0 : rd_ptr_q + 1'b1;
                cur_op_q <= q_op_o;
            end
            count_q <= count_q + cmd_valid_i - start;

            credit_o    <= (state_q == hyper_pkg::ST_DONE);
            rsp_valid_o <= (state_q == hyper_pkg::ST_DONE) && !is_write;

            cnt_q <= cnt_q + 1'b1;
            case (state_q)
                hyper_pkg::ST_CA: begin
                    if (cnt_q == CntW'(hyper_pkg::CaBytes - 1)) begin
                        state_q <= hyper_pkg::ST_LATENCY;
                        cnt_q   <= '0;
                    end
                end
                hyper_pkg::ST_LATENCY: begin
                    if (cnt_q == CntW'(Latency - 1)) begin
                        state_q <= hyper_pkg::ST_DATA;
                        cnt_q   <= '0;
                    end
                end
                hyper_pkg::ST_DATA: begin
                    if (cnt_q == CntW'(hyper_pkg::WordBytes - 1)) begin
                        state_q <= hyper_pkg::ST_DONE;
                        cnt_q   <= '0;
                    end
                end
                default: begin
                    state_q <= start ? hyper_pkg::ST_CA : hyper_pkg::ST_IDLE;
                    cnt_q   <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hyper_ctrl_top.sv ====
/*
 * HyperBus controller for single-word accesses to one HyperRAM.
 * The host starts with CmdCredits credits and gets one back per access.
 * Latency is fixed; RWDS latency doubling from the device is ignored.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_ctrl_top #(
    parameter int unsigned AddrWidth  = 20,
    parameter int unsigned Latency    = 6,
    parameter int unsigned CmdCredits = 2
) (
    input  logic                  sys_clk,
    input  logic                  reset_i,
    input  logic                  cmd_valid_i,
    input  hyper_pkg::hyper_op_e  cmd_op_i,
    input  logic [AddrWidth-1:0]  cmd_addr_i,
    input  logic [31:0]           cmd_wdata_i,
    input  logic [3:0]            cmd_be_i,
    output logic                  credit_o,
    output logic                  rsp_valid_o,
    output logic [31:0]           rsp_rdata_o,
    output logic                  hyper_cs_n_o,
    output logic                  hyper_ck_o,
    output logic                  hyper_reset_n_o,
    inout  wire  [7:0]            hyper_dq_io,
    inout  wire                   hyper_rwds_io
);

    hyper_pkg::hyper_op_e  q_op;
    logic [AddrWidth-1:0]  q_addr;
    logic [31:0]           q_wdata;
    logic [3:0]            q_be;
    logic                  ca_load, ca_shift;
    logic                  dp_load, dp_shift, dp_capture;
    logic [1:0]            byte_sel;
    logic                  bus_active, dq_oe, rwds_oe;
    logic [7:0]            ca_byte, wr_byte, rd_byte;
    logic                  wr_mask;

    hyper_ctrl_fsm #(
        .AddrWidth  (AddrWidth),
        .Latency    (Latency),
        .CmdCredits (CmdCredits)
    ) fsm_i (
        .sys_clk      (sys_clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cmd_addr_i   (cmd_addr_i),
        .cmd_wdata_i  (cmd_wdata_i),
        .cmd_be_i     (cmd_be_i),
        .credit_o     (credit_o),
        .rsp_valid_o  (rsp_valid_o),
        .q_op_o       (q_op),
        .q_addr_o     (q_addr),
        .q_wdata_o    (q_wdata),
        .q_be_o       (q_be),
        .ca_load_o    (ca_load),
        .ca_shift_o   (ca_shift),
        .dp_load_o    (dp_load),
        .dp_shift_o   (dp_shift),
        .dp_capture_o (dp_capture),
        .byte_sel_o   (byte_sel),
        .bus_active_o (bus_active),
        .dq_oe_o      (dq_oe),
        .rwds_oe_o    (rwds_oe)
    );

    hyper_ca_builder #(
        .AddrWidth (AddrWidth)
    ) ca_i (
        .sys_clk   (sys_clk),
        .reset_i   (reset_i),
        .load_i    (ca_load),
        .shift_i   (ca_shift),
        .op_i      (q_op),
        .addr_i    (q_addr),
        .ca_byte_o (ca_byte)
    );

    hyper_data_path dp_i (
        .sys_clk   (sys_clk),
        .reset_i   (reset_i),
        .load_i    (dp_load),
        .shift_i   (dp_shift),
        .capture_i (dp_capture),
        .wdata_i   (q_wdata),
        .be_i      (q_be),
        .rd_byte_i (rd_byte),
        .wr_byte_o (wr_byte),
        .wr_mask_o (wr_mask),
        .rd_word_o (rsp_rdata_o)
    );

    hyper_io_pad pad_i (
        .sys_clk    (sys_clk),
        .reset_i    (reset_i),
        .active_i   (bus_active),
        .byte_sel_i (byte_sel),
        .ca_byte_i  (ca_byte),
        .wr_byte_i  (wr_byte),
        .wr_mask_i  (wr_mask),
        .dq_oe_i    (dq_oe),
        .rwds_oe_i  (rwds_oe),
        .cs_n_o     (hyper_cs_n_o),
        .ck_o       (hyper_ck_o),
        .reset_n_o  (hyper_reset_n_o),
        .rd_byte_o  (rd_byte),
        .dq_io      (hyper_dq_io),
        .rwds_io    (hyper_rwds_io)
    );

endmodule

`default_nettype wire

// ==== verif/hyper_ram_model.sv ====
/*
 * Behavioral HyperRAM on the bus pins, sampled with the system clock.
 * Fixed latency (at least 1), memory space only, no RWDS read strobe.
 * Unwritten bytes read back as a pattern of their full byte address.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_ram_model #(
    parameter int unsigned Latency = 6
) (
    input  logic       sys_clk,
    input  logic       cs_n_i,
    input  logic       ck_i,
    input  logic       reset_n_i,
    inout  wire  [7:0] dq_io,
    inout  wire        rwds_io
);

    localparam int unsigned DataStart = hyper_pkg::CaBytes + Latency;
    localparam int unsigned DataEnd   = DataStart + hyper_pkg::WordBytes;

    logic [7:0]  mem [int unsigned];
    logic [47:0] ca_q;
    logic        ck_prev;
    logic [7:0]  dq_drv;
    logic        dq_en = 1'b0;
    int unsigned idx;

    assign dq_io = dq_en ? dq_drv : 8'bz;

    // Halfword address from the CA word, then byte address
    function automatic logic [31:0] byte_base(input logic [47:0] ca);
        logic [31:0] haddr;
        haddr = {ca[44:16], ca[2:0]};
        return {haddr[30:0], 1'b0};
    endfunction

    function automatic logic [7:0] read_byte(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5a;
    endfunction

    // One byte per CK edge while selected
    always @(posedge sys_clk) begin
        ck_prev <= ck_i;
        if (!reset_n_i || cs_n_i) begin
            idx   <= 0;
            dq_en <= 1'b0;
        end else if (ck_i !== ck_prev) begin
            if (idx < hyper_pkg::CaBytes) begin
                ca_q <= {ca_q[39:0], dq_io};
            end else if (idx >= DataStart && idx < DataEnd && !ca_q[hyper_pkg::CaRwBit]
                         && rwds_io === 1'b0) begin
                mem[byte_base(ca_q) + idx - DataStart] = dq_io;
            end
            // Read bytes go out one cycle ahead of their slot
            if (ca_q[hyper_pkg::CaRwBit] === 1'b1 && idx + 1 >= DataStart && idx + 1 < DataEnd) begin
                dq_en  <= 1'b1;
                dq_drv <= read_byte(byte_base(ca_q) + idx + 1 - DataStart);
            end else begin
                dq_en <= 1'b0;
            end
            idx <= idx + 1;
        end
    end

endmodule

`default_nettype wire

// ==== verif/hyper_checker.sv ====
/*
 * Host-side scoreboard. Expects in-order completion, one credit_o per
 * accepted command. Unwritten bytes follow the same address pattern
 * as the memory model.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_checker #(
    parameter int unsigned AddrWidth = 20
) (
    input  logic                 sys_clk,
    input  logic                 reset_i,
    input  logic                 cmd_valid_i,
    input  hyper_pkg::hyper_op_e cmd_op_i,
    input  logic [AddrWidth-1:0] cmd_addr_i,
    input  logic [31:0]          cmd_wdata_i,
    input  logic [3:0]           cmd_be_i,
    input  logic                 exp_valid_i,
    input  logic [31:0]          exp_data_i,
    input  logic                 credit_i,
    input  logic                 rsp_valid_i,
    input  logic [31:0]          rsp_rdata_i,
    input  logic                 cs_n_i,
    input  logic                 ck_i,
    input  logic                 reset_n_i,
    output int                   errors_o,
    output int                   checks_o
);

    logic [7:0]           ref_mem [int unsigned];
    hyper_pkg::hyper_op_e op_q [$];
    logic [AddrWidth-1:0] addr_q [$];
    logic [31:0]          want_q [$];
    logic                 tbl_valid_q [$];
    logic [31:0]          tbl_data_q [$];
    int                   errors = 0;
    int                   checks = 0;
    int                   rows_done = 0;
    logic                 started = 1'b0;

    assign errors_o = errors;
    assign checks_o = checks;

    function automatic logic [7:0] ref_byte(input logic [31:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5a;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    always @(posedge sys_clk) begin : monitor
        logic [31:0]          base;
        logic [31:0]          want;
        hyper_pkg::hyper_op_e op;
        logic [AddrWidth-1:0] addr;
        logic                 tbl_valid;
        logic [31:0]          tbl_data;
        // Device reset is low only while the controller is in reset
        if (reset_n_i !== !reset_i) begin
            report_mismatch("hyper_reset_n_o", !reset_i, reset_n_i);
        end
        if (!reset_i) begin
            // Bus and host outputs stay quiet until the first command
            if (!started) begin
                if (cs_n_i !== 1'b1) report_mismatch("hyper_cs_n_o", 1, cs_n_i);
                if (ck_i !== 1'b0) report_mismatch("hyper_ck_o", 0, ck_i);
                if (credit_i !== 1'b0) report_mismatch("credit_o", 0, credit_i);
                if (rsp_valid_i !== 1'b0) report_mismatch("rsp_valid_o", 0, rsp_valid_i);
            end
            if (credit_i) begin
                if (op_q.size() == 0) begin
                    report_error("credit_o pulsed with no command outstanding");
                end else begin
                    op        = op_q.pop_front();
                    addr      = addr_q.pop_front();
                    want      = want_q.pop_front();
                    tbl_valid = tbl_valid_q.pop_front();
                    tbl_data  = tbl_data_q.pop_front();
                    if (op == hyper_pkg::OP_READ) begin
                        checks++;
                        if (!rsp_valid_i) begin
                            report_error("read completed without rsp_valid_o");
                        end else begin
                            if (rsp_rdata_i !== want) begin
                                report_mismatch("rsp_rdata_o", want, rsp_rdata_i);
                            end
                            if (tbl_valid && rsp_rdata_i !== tbl_data) begin
                                report_mismatch("rsp_rdata_o", tbl_data, rsp_rdata_i);
                            end
                        end
                        $display("row %0d read  addr %05h data %08h", rows_done, addr, rsp_rdata_i);
                    end else begin
                        if (rsp_valid_i) report_error("rsp_valid_o pulsed for a write");
                        $display("row %0d write addr %05h done", rows_done, addr);
                    end
                    rows_done++;
                end
            end else if (rsp_valid_i) begin
                report_error("rsp_valid_o pulsed without credit_o");
            end
            if (cmd_valid_i) begin
                started = 1'b1;
                base    = 32'({cmd_addr_i, 2'b00});
                want    = '0;
                for (int j = 0; j < 4; j++) begin
                    if (cmd_op_i == hyper_pkg::OP_WRITE && cmd_be_i[j]) begin
                        ref_mem[base + j] = cmd_wdata_i[8*j +: 8];
                    end
                    want[8*j +: 8] = ref_byte(base + j);
                end
                op_q.push_back(cmd_op_i);
                addr_q.push_back(cmd_addr_i);
                want_q.push_back(want);
                tbl_valid_q.push_back(exp_valid_i);
                tbl_data_q.push_back(exp_data_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/hyper_ctrl_properties.sv ====
/*
 * Credit and pin protocol checks, bound into the controller top.
 * The state input comes from the FSM instance inside the top.
 */
`timescale 1ns/10ps
`default_nettype none

module hyper_ctrl_properties #(
    parameter int unsigned CmdCredits = 2
) (
    input logic                    sys_clk,
    input logic                    reset_i,
    input logic                    cmd_valid_i,
    input logic                    credit_i,
    input logic                    rsp_valid_i,
    input logic                    cs_n_i,
    input hyper_pkg::hyper_state_e state_i
);

    int outstanding = 0;
    int fail_count = 0;

    always @(posedge sys_clk) begin
        if (reset_i) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + (cmd_valid_i ? 1 : 0) - (credit_i ? 1 : 0);
        end
    end

    a_credit_bound: assert property (@(posedge sys_clk) disable iff (reset_i)
        outstanding <= int'(CmdCredits))
    else begin
        $error("more commands outstanding than credits");
        fail_count++;
    end

    a_issue_needs_credit: assert property (@(posedge sys_clk) disable iff (reset_i)
        cmd_valid_i |-> outstanding < int'(CmdCredits))
    else begin
        $error("command issued without a credit");
        fail_count++;
    end

    a_rsp_cs_high: assert property (@(posedge sys_clk) disable iff (reset_i)
        rsp_valid_i |-> cs_n_i)
    else begin
        $error("rsp_valid_o while chip select is active");
        fail_count++;
    end

    a_rsp_with_credit: assert property (@(posedge sys_clk) disable iff (reset_i)
        rsp_valid_i |-> credit_i)
    else begin
        $error("rsp_valid_o without credit_o");
        fail_count++;
    end

    // Command taken while idle reaches chip select one cycle after the FSM starts
    a_idle_start_cs: assert property (@(posedge sys_clk) disable iff (reset_i)
        cmd_valid_i && state_i == hyper_pkg::ST_IDLE |=> ##1 !cs_n_i)
    else begin
        $error("chip select not active one cycle after an idle start");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== verif/tb_hyper_ctrl.sv ====
/*
 * Testbench for the HyperBus controller. Directed rows come first,
 * then alternating random write and read-back rows.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_hyper_ctrl;

    localparam int unsigned AddrWidth  = 20;
    localparam int unsigned Latency    = 6;
    localparam int unsigned CmdCredits = 2;
    localparam int FixedRows     = 7;
    localparam int RandRows      = 20;
    localparam int NumRows       = FixedRows + RandRows;
    localparam int TimeoutCycles = NumRows * (Latency + 14) + 200;

    logic                 sys_clk;
    logic                 reset_i;
    logic                 cmd_valid;
    hyper_pkg::hyper_op_e cmd_op;
    logic [AddrWidth-1:0] cmd_addr;
    logic [31:0]          cmd_wdata;
    logic [3:0]           cmd_be;
    logic                 exp_valid;
    logic [31:0]          exp_data;
    logic                 credit, rsp_valid;
    logic [31:0]          rsp_rdata;
    logic                 hyper_cs_n, hyper_ck, hyper_reset_n;
    wire  [7:0]           hyper_dq;
    wire                  hyper_rwds;
    int                   chk_errors, chk_checks;
    int                   issued = 0;
    int                   returned = 0;
    int                   cycle_count = 0;

    // Stimulus table with expected read data where known by hand
    hyper_pkg::hyper_op_e tbl_op      [NumRows];
    logic [AddrWidth-1:0] tbl_addr    [NumRows];
    logic [31:0]          tbl_data    [NumRows];
    logic [3:0]           tbl_be      [NumRows];
    logic                 tbl_has_exp [NumRows];
    logic [31:0]          tbl_exp     [NumRows];

    bind hyper_ctrl_top hyper_ctrl_properties #(.CmdCredits(CmdCredits)) props_i (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .credit_i    (credit_o),
        .rsp_valid_i (rsp_valid_o),
        .cs_n_i      (hyper_cs_n_o),
        .state_i     (fsm_i.state_q)
    );

    hyper_ctrl_top #(
        .AddrWidth  (AddrWidth),
        .Latency    (Latency),
        .CmdCredits (CmdCredits)
    ) dut_i (
        .sys_clk         (sys_clk),
        .reset_i         (reset_i),
        .cmd_valid_i     (cmd_valid),
        .cmd_op_i        (cmd_op),
        .cmd_addr_i      (cmd_addr),
        .cmd_wdata_i     (cmd_wdata),
        .cmd_be_i        (cmd_be),
        .credit_o        (credit),
        .rsp_valid_o     (rsp_valid),
        .rsp_rdata_o     (rsp_rdata),
        .hyper_cs_n_o    (hyper_cs_n),
        .hyper_ck_o      (hyper_ck),
        .hyper_reset_n_o (hyper_reset_n),
        .hyper_dq_io     (hyper_dq),
        .hyper_rwds_io   (hyper_rwds)
    );

    hyper_ram_model #(.Latency(Latency)) ram_i (
        .sys_clk   (sys_clk),
        .cs_n_i    (hyper_cs_n),
        .ck_i      (hyper_ck),
        .reset_n_i (hyper_reset_n),
        .dq_io     (hyper_dq),
        .rwds_io   (hyper_rwds)
    );

    hyper_checker #(.AddrWidth(AddrWidth)) checker_i (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid),
        .cmd_op_i    (cmd_op),
        .cmd_addr_i  (cmd_addr),
        .cmd_wdata_i (cmd_wdata),
        .cmd_be_i    (cmd_be),
        .exp_valid_i (exp_valid),
        .exp_data_i  (exp_data),
        .credit_i    (credit),
        .rsp_valid_i (rsp_valid),
        .rsp_rdata_i (rsp_rdata),
        .cs_n_i      (hyper_cs_n),
        .ck_i        (hyper_ck),
        .reset_n_i   (hyper_reset_n),
        .errors_o    (chk_errors),
        .checks_o    (chk_checks)
    );

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        if (credit) begin
            returned <= returned + 1;
        end
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, %0d of %0d commands completed",
                     cycle_count, returned, NumRows);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic set_row(input int r, input hyper_pkg::hyper_op_e op,
                           input logic [AddrWidth-1:0] addr, input logic [31:0] data,
                           input logic [3:0] be, input logic has_exp, input logic [31:0] exp);
        tbl_op[r]      = op;
        tbl_addr[r]    = addr;
        tbl_data[r]    = data;
        tbl_be[r]      = be;
        tbl_has_exp[r] = has_exp;
        tbl_exp[r]     = exp;
    endtask

    task automatic build_table();
        logic [31:0]          seed;
        logic [AddrWidth-1:0] last_addr;
        logic [31:0]          data;
        seed      = 32'h4fa7;
        last_addr = '0;
        // Rows 0 and 1 go out back to back on both credits
        set_row(0, hyper_pkg::OP_WRITE, 20'h00010, 32'hdeadbeef, 4'hf, 1'b0, '0);
        set_row(1, hyper_pkg::OP_READ,  20'h00010, '0, 4'hf, 1'b1, 32'hdeadbeef);
        set_row(2, hyper_pkg::OP_WRITE, 20'h00123, 32'h11223344, 4'hf, 1'b0, '0);
        set_row(3, hyper_pkg::OP_WRITE, 20'h00123, 32'haabbccdd, 4'b0101, 1'b0, '0);
        set_row(4, hyper_pkg::OP_READ,  20'h00123, '0, 4'hf, 1'b1, 32'h11bb33dd);
        set_row(5, hyper_pkg::OP_WRITE, 20'hfffff, 32'h0f0f0f0f, 4'b1000, 1'b0, '0);
        set_row(6, hyper_pkg::OP_READ,  20'hfffff, '0, 4'hf, 1'b0, '0);
        for (int k = 0; k < RandRows; k++) begin
            if (k % 2 == 0) begin
                seed      = xorshift32(seed);
                last_addr = seed[AddrWidth-1:0];
                seed      = xorshift32(seed);
                data      = seed;
                seed      = xorshift32(seed);
                set_row(FixedRows + k, hyper_pkg::OP_WRITE, last_addr, data, seed[3:0], 1'b0, '0);
            end else begin
                set_row(FixedRows + k, hyper_pkg::OP_READ, last_addr, '0, 4'hf, 1'b0, '0);
            end
        end
    endtask

    task automatic drive_row(input int r);
        cmd_valid <= 1'b1;
        cmd_op    <= tbl_op[r];
        cmd_addr  <= tbl_addr[r];
        cmd_wdata <= tbl_data[r];
        cmd_be    <= tbl_be[r];
        exp_valid <= tbl_has_exp[r];
        exp_data  <= tbl_exp[r];
    endtask

    initial begin
        int row;
        int errors;
        sys_clk   = 1'b0;
        reset_i   = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = hyper_pkg::OP_WRITE;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_be    = '0;
        exp_valid = 1'b0;
        exp_data  = '0;
        build_table();
        repeat (10) @(posedge sys_clk);
        reset_i <= 1'b0;
        // Quiet window so the checker sees the idle pins
        repeat (8) @(posedge sys_clk);
        row = 0;
        while (row < NumRows) begin
            @(posedge sys_clk);
            if (int'(CmdCredits) - issued + returned > 0) begin
                drive_row(row);
                issued++;
                row++;
            end else begin
                cmd_valid <= 1'b0;
            end
        end
        @(posedge sys_clk);
        cmd_valid <= 1'b0;
        while (returned < NumRows) @(posedge sys_clk);
        // Tail catches any stray credit or response
        repeat (20) @(posedge sys_clk);
        errors = chk_errors + dut_i.props_i.fail_count;
        $display("Rows %0d, credits back %0d, reads checked %0d, errors %0d",
                 NumRows, returned, chk_checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/hyper_pkg.sv
verilog/hyper_ca_builder.sv
verilog/hyper_data_path.sv
verilog/hyper_io_pad.sv
verilog/hyper_ctrl_fsm.sv
verilog/hyper_ctrl_top.sv
verif/hyper_ram_model.sv
verif/hyper_checker.sv
verif/hyper_ctrl_properties.sv
verif/tb_hyper_ctrl.sv

// ==== Bender.yml ====
package:
  name: hyper_ctrl

sources:
  - files:
      - verilog/hyper_pkg.sv
      - verilog/hyper_ca_builder.sv
      - verilog/hyper_data_path.sv
      - verilog/hyper_io_pad.sv
      - verilog/hyper_ctrl_fsm.sv
      - verilog/hyper_ctrl_top.sv
  - target: test
    files:
      - verif/hyper_ram_model.sv
      - verif/hyper_checker.sv
      - verif/hyper_ctrl_properties.sv
      - verif/tb_hyper_ctrl.sv
